/* logic/play_pkg.sv */
package play_pkg;

    localparam int KEY_W    = 7;
    localparam int NAME_LEN = 8;
    localparam int SCORE_W  = 14;
    // Also bounds the chart length
    localparam int ADDR_W   = 8;

    // Points per timing window
    localparam logic [SCORE_W-1:0] PTS_PERFECT = SCORE_W'(10);
    localparam logic [SCORE_W-1:0] PTS_GREAT   = SCORE_W'(8);
    localparam logic [SCORE_W-1:0] PTS_GOOD    = SCORE_W'(5);

    // One-hot key, bit 0 is C; all zero is a rest
    typedef struct packed {
        logic             oct_down;
        logic             oct_up;
        logic [KEY_W-1:0] keys;
    } note_t;

    // Five arrow codes need a third bit
    typedef enum logic [2:0] {
        ARROW_NONE  = 3'd0,
        ARROW_UP    = 3'd1,
        ARROW_DOWN  = 3'd2,
        ARROW_LEFT  = 3'd3,
        ARROW_RIGHT = 3'd4
    } arrow_e;

    typedef struct packed {
        logic [7:0] user_id;
        arrow_e     arrow;
        note_t      key;
    } user_in_t;

    typedef struct packed {
        logic [NAME_LEN*8-1:0] name;
        logic [ADDR_W-1:0]     note_cnt;
    } chart_info_t;

    typedef struct packed {
        logic [7:0]            user_id;
        logic [NAME_LEN*8-1:0] name;
        logic [SCORE_W-1:0]    score;
    } play_record_t;

    typedef enum logic {
        PAGE_PLAY = 1'b0,
        PAGE_MENU = 1'b1
    } page_state_e;

endpackage

/* logic/beat_timer.sv */
module beat_timer #(
    parameter int STEP_DIV = 10_000_000,
    parameter int SCAN_DIV = 5_000_000
) (
    input  logic prog_clk,
    input  logic rst,
    output logic step_tick,
    output logic scan_tick
);
    localparam int CNT_W = $clog2(STEP_DIV + 1);

    logic [CNT_W-1:0] cnt;
    logic             cnt_wrap;

    assign cnt_wrap = (cnt == CNT_W'(STEP_DIV - 1));

    // Scan beat shares the step counter since SCAN_DIV divides STEP_DIV
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            step_tick <= 1'b0;
            scan_tick <= 1'b0;
        end else begin
            cnt       <= cnt_wrap ? '0 : cnt + 1'b1;
            step_tick <= cnt_wrap;
            scan_tick <= ((cnt % SCAN_DIV) == CNT_W'(SCAN_DIV - 1));
        end
    end

endmodule

/* logic/count_down.sv */
module count_down #(
    parameter int COUNT_STEPS = 10
) (
    input  logic       prog_clk,
    input  logic       rst,
    input  logic       step_tick,
    output logic [1:0] digit,
    output logic       play_st
);
    localparam int CNT_W = $clog2(COUNT_STEPS + 1);

    logic [CNT_W-1:0] step_cnt;
    logic             digit_done;

    assign digit_done = (step_cnt == CNT_W'(COUNT_STEPS - 1));

    // Lead-in 3, 2, 1, 0 then latch play start
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            step_cnt <= '0;
            digit    <= 2'd3;
            play_st  <= 1'b0;
        end else if (step_tick && !play_st) begin
            if (digit_done) begin
                step_cnt <= '0;
                if (digit == 2'd0) begin
                    play_st <= 1'b1;
                end else begin
                    digit <= digit - 2'd1;
                end
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/note_sequencer.sv */
module note_sequencer
    import play_pkg::*;
(
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              step_tick,
    input  logic              play_st,
    input  logic [ADDR_W-1:0] note_cnt,
    input  note_t             chart_note,
    output logic [ADDR_W-1:0] chart_addr,
    output note_t             cur_note,
    output logic              fin
);
    logic step_en;

    assign step_en = step_tick && play_st && !fin;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            chart_addr <= '0;
            cur_note   <= '0;
            fin        <= 1'b0;
        end else if (step_en) begin
            if (chart_addr < note_cnt) begin
                cur_note   <= chart_note;
                chart_addr <= chart_addr + 1'b1;
            end else begin
                // End of chart leaves a rest on the display
                fin      <= 1'b1;
                cur_note <= '0;
            end
        end
    end

endmodule

/* logic/score_judge.sv */
module score_judge
    import play_pkg::*;
(
    input  logic               prog_clk,
    input  logic               rst,
    input  logic               scan_tick,
    input  logic               play_st,
    input  logic               fin,
    input  note_t              key,
    input  note_t              cur_note,
    output logic [SCORE_W-1:0] score
);
    // hist[0] is one scan back, hist[2] three scans back
    note_t [2:0]        hist;
    logic [SCORE_W-1:0] pts;
    logic               judge_en;

    assign judge_en = scan_tick && play_st && !fin && (cur_note != '0);

    // Timing window, earliest match wins
    always_comb begin
        if (key == cur_note || hist[0] == cur_note) begin
            pts = PTS_PERFECT;
        end else if (hist[1] == cur_note) begin
            pts = PTS_GREAT;
        end else if (hist[2] == cur_note) begin
            pts = PTS_GOOD;
        end else begin
            pts = '0;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            hist  <= '0;
            score <= '0;
        end else if (judge_en) begin
            hist  <= {hist[1:0], key};
            score <= score + pts;
        end
    end

endmodule

/* logic/note_display.sv */
module note_display
    import play_pkg::*;
(
    input  logic        prog_clk,
    input  logic        rst,
    input  logic        play_st,
    input  logic [1:0]  digit,
    input  note_t       cur_note,
    output logic [63:0] seg_text,
    output logic [7:0]  led
);
    localparam logic [8*KEY_W-1:0] LETTERS = "cdefgab";

    logic [63:0] text_d;
    logic [7:0]  led_d;
    logic [7:0]  oct_char;

    always_comb begin
        text_d   = "        ";
        oct_char = " ";
        if (cur_note.oct_up) begin
            oct_char = "u";
        end else if (cur_note.oct_down) begin
            oct_char = "d";
        end
        if (!play_st) begin
            // Countdown digit as ASCII
            text_d = {8'h30 | {6'b0, digit}, "       "};
        end else begin
            // Rest or a bad key word stays blank
            for (int i = 0; i < KEY_W; i++) begin
                if (cur_note.keys == KEY_W'(1 << i)) begin
                    text_d = {LETTERS[8*(KEY_W-1-i) +: 8], " ", oct_char, " ",
                              8'h31 + 8'(i), "   "};
                end
            end
        end
    end

    // C lights the leftmost LED
    always_comb begin
        led_d = '0;
        for (int i = 0; i < KEY_W; i++) begin
            led_d[7-i] = cur_note.keys[i];
        end
        led_d[0] = cur_note.oct_up | cur_note.oct_down;
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            seg_text <= "        ";
            led      <= '0;
        end else begin
            seg_text <= text_d;
            led      <= led_d;
        end
    end

endmodule

/* logic/play_control.sv */
module play_control
    import play_pkg::*;
(
    input  logic                  prog_clk,
    input  logic                  rst,
    input  arrow_e                arrow,
    input  logic                  fin,
    input  logic [7:0]            user_id,
    input  logic [NAME_LEN*8-1:0] name,
    input  logic [SCORE_W-1:0]    score,
    output page_state_e           state,
    output logic                  save_strobe,
    output play_record_t          save_record
);
    logic save_go;

    assign save_go = (state == PAGE_PLAY) && (arrow == ARROW_RIGHT) && fin;

    // Menu is terminal until reset
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state       <= PAGE_PLAY;
            save_strobe <= 1'b0;
        end else begin
            save_strobe <= save_go;
            if (state == PAGE_PLAY && (arrow == ARROW_LEFT || save_go)) begin
                state <= PAGE_MENU;
            end
        end
    end

    // Record captured alongside the strobe
    always_ff @(posedge prog_clk) begin
        if (save_go) begin
            save_record <= '{user_id: user_id, name: name, score: score};
        end
    end

endmodule

/* logic/play_page_top.sv */
module play_page_top
    import play_pkg::*;
#(
    parameter int STEP_DIV    = 10_000_000,
    parameter int SCAN_DIV    = 5_000_000,
    parameter int COUNT_STEPS = 10
) (
    input  logic              prog_clk,
    input  logic              rst,
    input  user_in_t          user_in,
    input  chart_info_t       chart_info,
    input  note_t             chart_note,
    output logic [ADDR_W-1:0] chart_addr,
    output note_t             cur_note,
    output logic [63:0]       seg_text,
    output logic [7:0]        led,
    output logic [SCORE_W-1:0] score,
    output page_state_e       state,
    output logic              save_strobe,
    output play_record_t      save_record
);
    logic       step_tick;
    logic       scan_tick;
    logic [1:0] digit;
    logic       play_st;
    logic       fin;

    beat_timer #(.STEP_DIV(STEP_DIV), .SCAN_DIV(SCAN_DIV)) u_beat_timer (
        .prog_clk(prog_clk), .rst(rst),
        .step_tick(step_tick), .scan_tick(scan_tick)
    );

    count_down #(.COUNT_STEPS(COUNT_STEPS)) u_count_down (
        .prog_clk(prog_clk), .rst(rst), .step_tick(step_tick),
        .digit(digit), .play_st(play_st)
    );

    note_sequencer u_note_sequencer (
        .prog_clk(prog_clk), .rst(rst), .step_tick(step_tick), .play_st(play_st),
        .note_cnt(chart_info.note_cnt), .chart_note(chart_note),
        .chart_addr(chart_addr), .cur_note(cur_note), .fin(fin)
    );

    score_judge u_score_judge (
        .prog_clk(prog_clk), .rst(rst), .scan_tick(scan_tick), .play_st(play_st),
        .fin(fin), .key(user_in.key), .cur_note(cur_note), .score(score)
    );

    note_display u_note_display (
        .prog_clk(prog_clk), .rst(rst), .play_st(play_st), .digit(digit),
        .cur_note(cur_note), .seg_text(seg_text), .led(led)
    );

    play_control u_play_control (
        .prog_clk(prog_clk), .rst(rst), .arrow(user_in.arrow), .fin(fin),
        .user_id(user_in.user_id), .name(chart_info.name), .score(score),
        .state(state), .save_strobe(save_strobe), .save_record(save_record)
    );

endmodule

/* verif/play_page_tb.sv */
module play_page_tb
    import play_pkg::*;
();
    localparam int STEP_DIV    = 8;
    localparam int SCAN_DIV    = 4;
    localparam int COUNT_STEPS = 2;
    localparam int NOTES       = 16;
    localparam int LEAD_IN     = 4 * COUNT_STEPS * STEP_DIV;
    localparam int RUN_LIMIT   = LEAD_IN + (NOTES + 4) * STEP_DIV + 200;

    logic               prog_clk;
    logic               rst;
    user_in_t           user_in;
    chart_info_t        chart_info;
    note_t              chart_note;
    logic [ADDR_W-1:0]  chart_addr;
    note_t              cur_note;
    logic [63:0]        seg_text;
    logic [7:0]         led;
    logic [SCORE_W-1:0] score;
    page_state_e        state;
    logic               save_strobe;
    play_record_t       save_record;

    note_t chart [NOTES];
    string test_name [6] = '{"countdown", "note_stream", "display", "scoring", "save", "exit"};
    int    errs [6];
    int    n_cyc;
    int    run_cycles;
    int    run_idx;
    int    rise_cyc;
    int    disp_checks;
    int    strobes;

    // Reference model
    logic         m_step;
    logic         m_scan;
    logic         m_play;
    logic         m_fin;
    logic         m_save;
    int           m_ticks;
    int           m_addr;
    note_t        m_cur;
    note_t        m_hist [3];
    logic [SCORE_W-1:0] m_score;
    page_state_e  m_state;
    play_record_t m_rec;
    logic [7:0]   digits_seen [$];
    note_t        notes_seen [$];

    // Chart memory answers combinationally
    assign chart_note = (chart_addr < NOTES) ? chart[chart_addr] : '0;

    play_page_top #(
        .STEP_DIV(STEP_DIV), .SCAN_DIV(SCAN_DIV), .COUNT_STEPS(COUNT_STEPS)
    ) DUT (.*);

    always #2 prog_clk = ~prog_clk;

    always @(posedge prog_clk) begin
        if (rst) begin
            run_cycles = 0;
        end else begin
            run_cycles = run_cycles + 1;
            if (run_cycles > RUN_LIMIT) begin
                $display("Timeout: run did not finish within %0d cycles", RUN_LIMIT);
                $display("Something failed");
                $finish;
            end
        end
    end

    function automatic logic [63:0] expect_text(note_t n);
        string       letters;
        logic [7:0]  oct;
        logic [63:0] txt;
        letters = "cdefgab";
        oct = n.oct_up ? "u" : (n.oct_down ? "d" : " ");
        txt = "        ";
        for (int i = 0; i < KEY_W; i++) begin
            if (n.keys == 7'(1 << i)) begin
                txt = {letters[i], " ", oct, " ", 8'(8'h31 + i), "   "};
            end
        end
        return txt;
    endfunction

    function automatic logic [7:0] expect_led(note_t n);
        logic [7:0] v;
        for (int i = 0; i < KEY_W; i++) begin
            v[7-i] = n.keys[i];
        end
        v[0] = n.oct_up | n.oct_down;
        return v;
    endfunction

    function automatic int window_points(note_t key, note_t cur);
        if (key == cur || m_hist[0] == cur) return 10;
        if (m_hist[1] == cur) return 8;
        if (m_hist[2] == cur) return 5;
        return 0;
    endfunction

    task automatic note_error(int t, string what, logic [127:0] exp, logic [127:0] act);
        $display("Error %s: %s expected %0h, actual %0h", test_name[t], what, exp, act);
        errs[t]++;
    endtask

    task automatic note_failure(int t, string msg);
        $display("Test %s: %s", test_name[t], msg);
        errs[t]++;
    endtask

    task automatic report_test(int t);
        if (errs[t] == 0) begin
            $display("Test %s: passed", test_name[t]);
        end else begin
            $display("Test %s: failed with %0d errors", test_name[t], errs[t]);
        end
    endtask

    task automatic start_run(int idx);
        run_idx = idx;
        rst = 1'b1;
        user_in.arrow = ARROW_NONE;
        m_step = 1'b0;
        m_scan = 1'b0;
        m_play = 1'b0;
        m_fin = 1'b0;
        m_save = 1'b0;
        m_ticks = 0;
        m_addr = 0;
        m_cur = '0;
        m_hist = '{default: '0};
        m_score = '0;
        m_state = PAGE_PLAY;
        rise_cyc = 0;
        disp_checks = 0;
        strobes = 0;
        repeat (3) @(posedge prog_clk);
        #1;
        rst = 1'b0;
        n_cyc = 0;
    endtask

    // Next state from the values held before this edge
    task automatic update_model();
        logic        old_step;
        logic        old_scan;
        logic        old_play;
        logic        old_fin;
        note_t       old_cur;
        page_state_e old_state;
        old_step = m_step;
        old_scan = m_scan;
        old_play = m_play;
        old_fin = m_fin;
        old_cur = m_cur;
        old_state = m_state;
        m_step = (n_cyc % STEP_DIV == 0);
        m_scan = (n_cyc % SCAN_DIV == 0);
        m_save = (old_state == PAGE_PLAY) && (user_in.arrow == ARROW_RIGHT) && old_fin;
        if (m_save) begin
            m_rec = '{user_id: user_in.user_id, name: chart_info.name, score: m_score};
        end
        if (old_state == PAGE_PLAY && (user_in.arrow == ARROW_LEFT || m_save)) begin
            m_state = PAGE_MENU;
        end
        if (old_scan && old_play && !old_fin && old_cur != '0) begin
            m_score = m_score + SCORE_W'(window_points(user_in.key, old_cur));
            m_hist[2] = m_hist[1];
            m_hist[1] = m_hist[0];
            m_hist[0] = user_in.key;
        end
        if (old_step && old_play && !old_fin) begin
            if (m_addr < NOTES) begin
                m_cur = chart[m_addr];
                m_addr++;
                if (run_idx == 0) notes_seen.push_back(cur_note);
            end else begin
                m_fin = 1'b1;
                m_cur = '0;
            end
        end
        if (old_step && !old_play) begin
            m_ticks++;
            if (m_ticks == 4 * COUNT_STEPS) begin
                m_play = 1'b1;
            end
        end
    endtask

    task automatic check_outputs(note_t prev_cur);
        if (cur_note !== m_cur) note_error(1, "cur_note", m_cur, cur_note);
        if (chart_addr !== ADDR_W'(m_addr)) note_error(1, "chart_addr", m_addr, chart_addr);
        if (prev_cur != '0) begin
            disp_checks++;
            if (seg_text !== expect_text(prev_cur)) begin
                note_error(2, "seg_text", expect_text(prev_cur), seg_text);
            end
            if (led !== expect_led(prev_cur)) note_error(2, "led", expect_led(prev_cur), led);
        end
        if (state !== m_state) note_error(4 + run_idx, "state", m_state, state);
        if (save_strobe !== m_save) note_error(4 + run_idx, "save_strobe", m_save, save_strobe);
        if (save_strobe === 1'b1) begin
            strobes++;
            if (save_record !== m_rec) note_error(4 + run_idx, "save_record", m_rec, save_record);
        end
        // Digit character until the display goes blank at play start
        if (run_idx == 0 && rise_cyc == 0) begin
            if (seg_text[63:56] >= "0" && seg_text[63:56] <= "3") begin
                if (digits_seen.size() == 0 || digits_seen[$] != seg_text[63:56]) begin
                    digits_seen.push_back(seg_text[63:56]);
                end
            end else if (n_cyc > 1) begin
                rise_cyc = n_cyc;
            end
        end
    endtask

    // New key right after the edge that consumed a scan tick
    task automatic drive_key();
        int r;
        int idx;
        if (n_cyc % SCAN_DIV == 1) begin
            r = $urandom % 5;
            idx = m_addr - 1 - r;
            if (r < 4 && idx >= 0) begin
                user_in.key = chart[idx];
            end else begin
                user_in.key = 9'($urandom);
            end
        end
    endtask

    task automatic run_cycle();
        note_t prev_cur;
        @(posedge prog_clk);
        #1;
        n_cyc++;
        prev_cur = m_cur;
        update_model();
        check_outputs(prev_cur);
        drive_key();
    endtask

    initial begin
        int oct_sel;
        int total;
        int failed;
        void'($urandom(32'h564f343c));
        prog_clk = 1'b0;
        rst = 1'b1;
        user_in = '0;
        user_in.user_id = 8'($urandom);
        chart_info.name = "tb_chart";
        chart_info.note_cnt = ADDR_W'(NOTES);
        errs = '{default: 0};
        for (int i = 0; i < NOTES; i++) begin
            oct_sel = $urandom % 3;
            chart[i].keys = 7'(1 << ($urandom % KEY_W));
            chart[i].oct_up = (oct_sel == 1);
            chart[i].oct_down = (oct_sel == 2);
        end

        start_run(0);
        while (!m_fin) run_cycle();
        repeat (4) run_cycle();
        user_in.arrow = ARROW_RIGHT;
        repeat (3) run_cycle();
        user_in.arrow = ARROW_NONE;
        repeat (2) run_cycle();

        if (digits_seen.size() != 4) begin
            note_failure(0, "countdown did not show four distinct digits");
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (digits_seen[i] != 8'h33 - i) note_error(0, "digit", 8'h33 - i, digits_seen[i]);
            end
        end
        if (rise_cyc - 1 != LEAD_IN + 1) begin
            note_error(0, "play start cycle", LEAD_IN + 1, rise_cyc - 1);
        end
        report_test(0);
        if (notes_seen.size() != NOTES) begin
            note_failure(1, $sformatf("saw %0d chart notes instead of %0d",
                                      notes_seen.size(), NOTES));
        end else begin
            for (int i = 0; i < NOTES; i++) begin
                if (notes_seen[i] !== chart[i]) note_error(1, "chart note", chart[i], notes_seen[i]);
            end
        end
        if (chart_addr !== ADDR_W'(NOTES)) note_error(1, "final chart_addr", NOTES, chart_addr);
        if (cur_note !== '0) note_error(1, "final cur_note", 0, cur_note);
        report_test(1);
        if (disp_checks == 0) note_failure(2, "no note was ever shown on the display");
        report_test(2);
        if (score !== m_score) note_error(3, "final score", m_score, score);
        report_test(3);
        if (strobes != 1) note_failure(4, $sformatf("expected one save strobe, saw %0d", strobes));
        if (state !== PAGE_MENU) note_error(4, "final state", PAGE_MENU, state);
        report_test(4);

        // Second run leaves during the countdown
        start_run(1);
        repeat (20) run_cycle();
        user_in.arrow = ARROW_LEFT;
        run_cycle();
        user_in.arrow = ARROW_NONE;
        run_cycle();
        if (state !== PAGE_MENU) note_failure(5, "left arrow did not leave the play page");
        while (!m_fin) run_cycle();
        user_in.arrow = ARROW_RIGHT;
        repeat (3) run_cycle();
        user_in.arrow = ARROW_NONE;
        run_cycle();
        if (strobes != 0) note_failure(5, "a save strobe appeared after leaving the page");
        report_test(5);

        total = 0;
        failed = 0;
        for (int i = 0; i < 6; i++) begin
            total += errs[i];
            if (errs[i] != 0) failed++;
        end
        $display("Tests: 6, passed: %0d, failed: %0d, errors: %0d", 6 - failed, failed, total);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* src.f */
logic/play_pkg.sv
logic/beat_timer.sv
logic/count_down.sv
logic/note_sequencer.sv
logic/score_judge.sv
logic/note_display.sv
logic/play_control.sv
logic/play_page_top.sv
verif/play_page_tb.sv
